// File: include/lb_settings.svh
`ifndef LB_SETTINGS_SVH
`define LB_SETTINGS_SVH

// bits per pixel
`define LB_PIX_W 8

// longest supported line, also the depth of each line delay
`define LB_MAX_LINE 64

// bits of a column or row coordinate
`define LB_COORD_W 16

`endif

// File: sim/lb_patterns.txt
# columns: case name, line width, frame height, zero padding (1/0), expected window count
# padded frames give width*height windows, unpadded ones (width-2)*(height-2)
pad_w5_h4 5 4 1 20
nopad_w5_h4 5 4 0 6
pad_w3_h3 3 3 1 9
nopad_w3_h5 3 5 0 3
pad_w64_h3 64 3 1 192
nopad_w64_h4 64 4 0 124
pad_w8_h6 8 6 1 48
nopad_w7_h7 7 7 0 25
pad_w6_h2 6 2 1 12
nopad_w5_h3 5 3 0 3

// File: sim/lb_tb.sv
`default_nettype none

`include "lb_settings.svh"

module lb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lb_pkg::*;

  localparam int WIN_W       = 9 * `LB_PIX_W;
  localparam int CYCLE_LIMIT = 20000;  // per frame
  localparam int DRAIN_LIMIT = 8;      // busy must drop within this

  logic    clk;
  logic    rst_n;
  logic    start;
  lb_cfg_t cfg_in;
  logic    pix_valid;
  pix_t    pix_data;
  logic    pix_ready;
  logic    win_valid;
  win_t    win_data;
  logic    win_ready;
  logic    busy;

  pix_t frame [$];    // pixels of the current frame, raster order
  win_t exp_win [$];  // expected windows in output order

  lb_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg_in    (cfg_in),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .pix_ready (pix_ready),
    .win_valid (win_valid),
    .win_data  (win_data),
    .win_ready (win_ready),
    .busy      (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;  // 4 ns period
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string test, input logic [WIN_W-1:0] expected,
                           input logic [WIN_W-1:0] actual);
    if (actual !== expected)
      report_failure($sformatf("MISMATCH %s expected %0h actual %0h",
                               test, expected, actual));
  endtask

  // window ending at (r,c): entry ro*3+co is pixel (r-2+ro, c-2+co)
  function automatic win_t model_window(input int r, input int c, input int w);
    win_t wv;
    int   rr;
    int   cc;
    for (int ro = 0; ro < 3; ro++)
      for (int co = 0; co < 3; co++)
      begin
        rr = r - 2 + ro;
        cc = c - 2 + co;
        if (rr < 0 || cc < 0)
          wv[ro*3+co] = '0;  // above or left of the frame
        else
          wv[ro*3+co] = frame[rr*w+cc];
      end
    return wv;
  endfunction

  // random frame, then every window the DUT should emit
  task automatic build_model(input int w, input int h, input int pad);
    frame.delete();
    exp_win.delete();
    for (int p = 0; p < w * h; p++)
      frame.push_back(pix_t'($urandom));
    for (int r = 0; r < h; r++)
      for (int c = 0; c < w; c++)
        if (pad != 0 || (r >= 2 && c >= 2))
          exp_win.push_back(model_window(r, c, w));
  endtask

  task automatic run_case(input string name, input int w, input int h, input int pad,
                          input int count);
    int   idx;        // next pixel to offer
    int   got;        // windows taken
    int   cycles;
    logic offering;   // pixel on the bus, held until taken
    logic held;       // window stalled last cycle
    win_t held_data;
    logic want_win;   // kept window due one cycle after accept
    if (w < 3 || w > `LB_MAX_LINE || h < 1)
      report_failure({"pattern line out of range for case ", name});
    build_model(w, h, pad);
    check_val({name, "/model_count"}, count, exp_win.size());
    idx       = 0;
    got       = 0;
    cycles    = 0;
    offering  = 1'b0;
    held      = 1'b0;
    held_data = '0;
    want_win  = 1'b0;
    @(negedge clk);
    pix_valid       = 1'b0;
    start           = 1'b1;
    cfg_in.width    = coord_t'(w);
    cfg_in.height   = coord_t'(h);
    cfg_in.zero_pad = (pad != 0);
    while (idx < w * h || got < exp_win.size())
    begin
      @(negedge clk);
      start  = 1'b0;
      cfg_in = '0;  // already latched
      if (!offering && idx < w * h)
        offering = ($urandom % 4) != 0;  // random input gaps
      pix_valid = offering;
      if (offering)
        pix_data = frame[idx];
      else
        pix_data = pix_t'($urandom);  // junk while idle
      win_ready = ($urandom % 3) != 0;  // random output stalls
      #1;
      check_val({name, "/busy"}, 1, busy);
      if (held)
      begin
        check_val({name, "/hold_valid"}, 1, win_valid);
        check_val({name, "/hold_data"}, held_data, win_data);
      end
      if (want_win)
        check_val({name, "/latency"}, 1, win_valid);
      want_win = 1'b0;
      if (win_valid && win_ready)
      begin
        if (got >= exp_win.size())
          report_failure({"extra window delivered in case ", name});
        check_val($sformatf("%s/win%0d", name, got), exp_win[got], win_data);
        got++;
      end
      held      = win_valid && !win_ready;
      held_data = win_data;
      if (pix_valid && pix_ready)
      begin
        want_win = (pad != 0) || ((idx / w) >= 2 && (idx % w) >= 2);
        idx++;
        offering = 1'b0;
      end
      cycles++;
      if (cycles > CYCLE_LIMIT)
        report_failure({"timeout waiting for pixels or windows in case ", name});
    end
    check_val({name, "/count"}, count, got);
    // drain, busy has to drop with no further output
    cycles = 0;
    do
    begin
      @(negedge clk);
      pix_valid = 1'b0;
      win_ready = 1'b1;
      #1;
      check_val({name, "/no_extra_win"}, 0, win_valid);
      check_val({name, "/ready_after_frame"}, 0, pix_ready);
      cycles++;
      if (cycles > DRAIN_LIMIT)
        report_failure({"timeout waiting for busy to fall in case ", name});
    end
    while (busy);
  endtask

  initial
  begin
    int    fd;
    int    n;
    int    cases;
    int    w;
    int    h;
    int    pad;
    int    count;
    string line;
    string name;
    void'($urandom(77118));
    rst_n      = 1'b0;
    start      = 1'b0;
    cfg_in     = '0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    win_ready  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n     = 1'b1;
    pix_valid = 1'b1;  // offered before start, must be ignored
    pix_data  = pix_t'($urandom);
    win_ready = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      #1;
      check_val("pre_start/busy", 0, busy);
      check_val("pre_start/pix_ready", 0, pix_ready);
      check_val("pre_start/win_valid", 0, win_valid);
    end
    fd = $fopen("sim/lb_patterns.txt", "r");
    if (fd == 0)
      report_failure("cannot open sim/lb_patterns.txt");
    cases = 0;
    while (!$feof(fd))
    begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%s %d %d %d %d", name, w, h, pad, count);
        if (n != 5)
          report_failure({"bad line in pattern file: ", line});
        run_case(name, w, h, pad, count);  // frames run back to back
        cases++;
      end
    end
    $fclose(fd);
    if (cases == 0)
      report_failure("no test cases found in pattern file");
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
src/lb_pkg.sv
src/lb_ctrl_fsm.sv
src/lb_pos_counter.sv
src/lb_line_store.sv
src/lb_border_mask.sv
src/lb_top.sv
sim/lb_tb.sv

// File: src/lb_border_mask.sv
`default_nettype none

module lb_border_mask (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            run,
  input  wire logic            pix_valid,
  input  wire logic            win_ready,
  input  wire logic            zero_pad,
  input  wire lb_pkg::win_t    win,
  input  wire lb_pkg::lb_pos_t win_pos,
  input  wire logic            valid_stb,
  output logic                 accept,
  output logic                 pix_ready,
  output logic                 out_empty,
  output logic                 win_valid,
  output lb_pkg::win_t         win_data
);

  import lb_pkg::*;

  mask_t keep_tap;  // per-entry keep
  logic  keep_win;  // window goes out at all
  logic  pending;   // window held under back-pressure

  // border mask from the newest pixel position
  always_comb
  begin
    keep_tap = '1;
    if (win_pos.row == '0)
      keep_tap[5:0] = '0;  // rows r-2 and r-1 above the frame
    else if (win_pos.row == coord_t'(1))
      keep_tap[2:0] = '0;  // only r-2 above

    if (win_pos.col == '0)
    begin
      // col_off 0 and 1 left of the frame
      keep_tap[0] = 1'b0;
      keep_tap[1] = 1'b0;
      keep_tap[3] = 1'b0;
      keep_tap[4] = 1'b0;
      keep_tap[6] = 1'b0;
      keep_tap[7] = 1'b0;
    end
    else if (win_pos.col == coord_t'(1))
    begin
      keep_tap[0] = 1'b0;  // col_off 0 only
      keep_tap[3] = 1'b0;
      keep_tap[6] = 1'b0;
    end
  end

  // without padding only full interior windows
  assign keep_win = zero_pad || ((win_pos.row >= coord_t'(2)) && (win_pos.col >= coord_t'(2)));

  // store regs do not move while held, so the data stays put
  always_comb
  begin
    for (int i = 0; i < 9; i++)
      win_data[i] = (zero_pad && !keep_tap[i]) ? '0 : win[i];
  end

  assign win_valid = (valid_stb && keep_win) || pending;
  assign out_empty = !win_valid;

  // hold until taken
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pending <= 1'b0;
    else
      pending <= win_valid && !win_ready;
  end

  // input moves only when the output slot frees up this cycle
  assign pix_ready = run && (out_empty || win_ready);
  assign accept    = pix_valid && pix_ready;

endmodule

`default_nettype wire

// File: src/lb_ctrl_fsm.sv
`default_nettype none

module lb_ctrl_fsm (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            start,
  input  wire lb_pkg::lb_cfg_t cfg_in,
  input  wire logic            accept,
  input  wire logic            frame_end,
  input  wire logic            out_empty,
  output lb_pkg::lb_cfg_t      cfg,
  output logic                 clear,
  output logic                 run,
  output logic                 busy
);

  import lb_pkg::*;

  lb_state_e state;
  lb_state_e state_nxt;
  logic      start_ok;

  assign start_ok = start && (state == LB_IDLE);  // start ignored while busy

  // next state
  always_comb
  begin
    state_nxt = state;
    unique case (state)
      LB_IDLE:
        if (start_ok)
          state_nxt = LB_RUN;
      LB_RUN:
        if (accept && frame_end)
          state_nxt = LB_LAST;  // last pixel taken, drain output
      LB_LAST:
        if (out_empty)
          state_nxt = LB_IDLE;
      default:
        state_nxt = LB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= LB_IDLE;
      cfg   <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (start_ok)
        cfg <= cfg_in;  // frame settings held until next start
    end
  end

  assign clear = start_ok;             // counter back to (0,0) on start edge
  assign run   = (state == LB_RUN);    // input side open
  assign busy  = (state != LB_IDLE);

endmodule

`default_nettype wire

// File: src/lb_line_store.sv
`default_nettype none

`include "lb_settings.svh"

module lb_line_store (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            accept,
  input  wire lb_pkg::coord_t  width,
  input  wire lb_pkg::pix_t    pix_data,
  input  wire lb_pkg::lb_pos_t pos,
  output lb_pkg::win_t         win,
  output lb_pkg::lb_pos_t      win_pos,
  output logic                 valid_stb
);

  import lb_pkg::*;

  localparam int TAP_W = $clog2(`LB_MAX_LINE);

  pix_t             line1 [`LB_MAX_LINE];  // previous row
  pix_t             line2 [`LB_MAX_LINE];  // row before that
  logic [TAP_W-1:0] tap;
  pix_t             up1;
  pix_t             up2;

  // line1[k] holds the pixel taken k+1 accepts ago, so width-1 is one row up
  assign tap = TAP_W'(width - coord_t'(1));
  assign up1 = line1[tap];
  assign up2 = line2[tap];  // fed from the line1 tap, two rows up

  // two runtime-length line delays
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      line1[0] <= pix_data;
      line2[0] <= up1;
      for (int k = 1; k < `LB_MAX_LINE; k++)
      begin
        line1[k] <= line1[k-1];
        line2[k] <= line2[k-1];
      end
    end
  end

  // sliding 3x3, each row shifts left, new column enters at col_off 2
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      for (int r = 0; r < 3; r++)
      begin
        win[r*3]   <= win[r*3+1];
        win[r*3+1] <= win[r*3+2];
      end
      win[2]  <= up2;       // (r-2,c)
      win[5]  <= up1;       // (r-1,c)
      win[8]  <= pix_data;  // (r,c)
      win_pos <= pos;       // position of newest pixel
    end
  end

  // window fresh in the cycle after an accept
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_stb <= 1'b0;
    else
      valid_stb <= accept;
  end

endmodule

`default_nettype wire

// File: src/lb_pkg.sv
`default_nettype none

`include "lb_settings.svh"

package lb_pkg;

  typedef logic [`LB_PIX_W-1:0] pix_t;      // one pixel
  typedef logic [`LB_COORD_W-1:0] coord_t;  // column, row, width or height

  // 3x3 window, entry = row_off*3 + col_off
  // entry 8 is the newest pixel (r,c), entry 0 is (r-2,c-2)
  typedef pix_t [8:0] win_t;

  typedef logic [8:0] mask_t;  // keep bit per window entry

  // runtime frame settings, taken at start
  typedef struct packed {
    coord_t width;
    coord_t height;
    logic   zero_pad;
  } lb_cfg_t;

  // position of the pixel on offer
  typedef struct packed {
    coord_t col;
    coord_t row;
    logic   line_end;   // col == width-1
    logic   frame_end;  // line_end on the last row
  } lb_pos_t;

  typedef enum logic [1:0] {
    LB_IDLE = 2'd0,
    LB_RUN  = 2'd1,
    LB_LAST = 2'd2
  } lb_state_e;

endpackage

`default_nettype wire

// File: src/lb_pos_counter.sv
`default_nettype none

module lb_pos_counter (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           clear,
  input  wire logic           accept,
  input  wire lb_pkg::coord_t width,
  input  wire lb_pkg::coord_t height,
  output lb_pkg::lb_pos_t     pos
);

  import lb_pkg::*;

  coord_t col;
  coord_t row;
  logic   line_end;
  logic   frame_end;

  // end flags straight off the count
  assign line_end  = (col == width - coord_t'(1));
  assign frame_end = line_end && (row == height - coord_t'(1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      col <= '0;
      row <= '0;
    end
    else if (clear)
    begin
      col <= '0;  // new frame
      row <= '0;
    end
    else if (accept)
    begin
      if (line_end)
      begin
        col <= '0;
        // wrap row at frame end, next frame restarts anyway
        if (frame_end)
          row <= '0;
        else
          row <= row + coord_t'(1);
      end
      else
      begin
        col <= col + coord_t'(1);
      end
    end
  end

  always_comb
  begin
    pos.col       = col;
    pos.row       = row;
    pos.line_end  = line_end;
    pos.frame_end = frame_end;
  end

endmodule

`default_nettype wire

// File: src/lb_top.sv
`default_nettype none

module lb_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            start,
  input  wire lb_pkg::lb_cfg_t cfg_in,
  input  wire logic            pix_valid,
  input  wire lb_pkg::pix_t    pix_data,
  output logic                 pix_ready,
  output logic                 win_valid,
  output lb_pkg::win_t         win_data,
  input  wire logic            win_ready,
  output logic                 busy
);

  import lb_pkg::*;

  lb_cfg_t cfg;        // latched settings
  logic    clear;
  logic    run;
  logic    accept;     // pixel handshake
  logic    out_empty;
  lb_pos_t pos;        // position of the pixel on offer
  win_t    win;        // raw window from the store
  lb_pos_t win_pos;
  logic    valid_stb;

  lb_ctrl_fsm u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg_in    (cfg_in),
    .accept    (accept),
    .frame_end (pos.frame_end),
    .out_empty (out_empty),
    .cfg       (cfg),
    .clear     (clear),
    .run       (run),
    .busy      (busy)
  );

  lb_pos_counter u_pos (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .accept (accept),
    .width  (cfg.width),
    .height (cfg.height),
    .pos    (pos)
  );

  lb_line_store u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .width     (cfg.width),
    .pix_data  (pix_data),
    .pos       (pos),
    .win       (win),
    .win_pos   (win_pos),
    .valid_stb (valid_stb)
  );

  lb_border_mask u_mask (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .pix_valid (pix_valid),
    .win_ready (win_ready),
    .zero_pad  (cfg.zero_pad),
    .win       (win),
    .win_pos   (win_pos),
    .valid_stb (valid_stb),
    .accept    (accept),
    .pix_ready (pix_ready),
    .out_empty (out_empty),
    .win_valid (win_valid),
    .win_data  (win_data)
  );

endmodule

`default_nettype wire
